// File: hdl/pe_consts.svh
`ifndef PE_CONSTS_SVH
`define PE_CONSTS_SVH

//////////////////////////////
// lane geometry
//////////////////////////////

// bits per lane
`define PE_LANE_W 8

// lanes per operand word
`define PE_LANES 4

// instruction word
`define PE_INST_W 32

//////////////////////////////
// timing and buffering
//////////////////////////////

// register stages inside one lane
`define PE_LANE_LAT 3

// result buffer entries, also the credits handed out at reset
`define PE_WB_DEPTH 4

`endif

// File: hdl/pe_pkg.sv
`default_nettype none

package pe_pkg;

    `include "pe_consts.svh"

    //////////////////////////////
    // data widths
    //////////////////////////////

    typedef logic [`PE_LANE_W-1:0]            lane_data_t; // one lane operand/result
    typedef logic [`PE_LANES*`PE_LANE_W-1:0]  word_t;      // lane i at [8i+7:8i]
    typedef logic [`PE_INST_W-1:0]            inst_t;      // opcode [31:29], imm [7:0]

    // occupancy / credits, must reach PE_WB_DEPTH itself
    typedef logic [$clog2(`PE_WB_DEPTH+1)-1:0] credit_t;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    typedef logic [2:0] opcode_t;

    localparam opcode_t op_load = 3'b000; // 3'b100 decodes as load too
    localparam opcode_t op_add  = 3'b001;
    localparam opcode_t op_sub  = 3'b010;
    localparam opcode_t op_mul  = 3'b011;
    localparam opcode_t op_addi = 3'b101; // bit 2 set -> imm broadcast
    localparam opcode_t op_subi = 3'b110;
    localparam opcode_t op_muli = 3'b111;

    //////////////////////////////
    // lane operation
    //////////////////////////////

    typedef logic [1:0] lane_mode_t;

    localparam lane_mode_t mode_pass = 2'd0; // result = a
    localparam lane_mode_t mode_add  = 2'd1;
    localparam lane_mode_t mode_sub  = 2'd2;
    localparam lane_mode_t mode_mul  = 2'd3; // low 8 bits of a*b

endpackage

`default_nettype wire

// File: hdl/pe_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

// one lane's command, decoder -> lane
// no ready: lanes take a command every cycle, credits keep room downstream
interface lane_cmd_if
    import pe_pkg::*;
();

    logic       valid; // command present this cycle
    lane_mode_t mode;  // pass/add/sub/mul
    lane_data_t a;     // operand a slice
    lane_data_t b;     // opb slice or broadcast imm

    // decoder side
    modport master (
        output valid,
        output mode,
        output a,
        output b
    );

    // lane side
    modport slave (
        input valid,
        input mode,
        input a,
        input b
    );

endinterface

`default_nettype wire

// File: hdl/pe_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module pe_decoder
    import pe_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              inst_valid,
    output logic             inst_ready,
    input  wire inst_t       inst,
    input  wire word_t       opa,
    input  wire word_t       opb,
    input  wire              credit_return, // one pulse per popped result
    lane_cmd_if.master       lanes [`PE_LANES]
);

    //////////////////////////////
    // credits / handshake
    //////////////////////////////

    credit_t credits;
    logic    accept;

    assign inst_ready = (credits != '0); // every in-flight op owns a buffer slot
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(`PE_WB_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1; // spend
                2'b01:   credits <= credits + 1'b1; // regain
                default: credits <= credits;        // both or neither
            endcase
        end
    end

    //////////////////////////////
    // capture stage
    //////////////////////////////

    logic       cap_valid;
    opcode_t    cap_op;
    lane_data_t cap_imm;
    word_t      cap_opa;
    word_t      cap_opb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= accept;
        end
    end

    // payload only, loads on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_op  <= inst[31:29];
            cap_imm <= inst[7:0]; // rest of inst is don't care
            cap_opa <= opa;
            cap_opb <= opb;
        end
    end

    //////////////////////////////
    // opcode table
    //////////////////////////////

    lane_mode_t dec_mode;
    logic       use_imm;

    always_comb begin
        case (cap_op)
            op_load:          dec_mode = mode_pass;
            op_add,  op_addi: dec_mode = mode_add;
            op_sub,  op_subi: dec_mode = mode_sub;
            op_mul,  op_muli: dec_mode = mode_mul;
            default:          dec_mode = mode_pass; // 3'b100, alias of load
        endcase
    end

    // load ignores b entirely, so no imm for it
    assign use_imm = cap_op[2] && (dec_mode != mode_pass);

    //////////////////////////////
    // per-lane command regs
    //////////////////////////////

    for (genvar i = 0; i < `PE_LANES; i++) begin : g_lane_cmd
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lanes[i].valid <= 1'b0;
            end else begin
                lanes[i].valid <= cap_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (cap_valid) begin
                lanes[i].mode <= dec_mode;
                lanes[i].a    <= cap_opa[i*`PE_LANE_W +: `PE_LANE_W];
                lanes[i].b    <= use_imm ? cap_imm
                                         : cap_opb[i*`PE_LANE_W +: `PE_LANE_W];
            end
        end
    end

    // credit accounting must never hand out more slots than the buffer has
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= credit_t'(`PE_WB_DEPTH));

    // stalled request holds still until taken
    a_inst_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid && !inst_ready) |=>
            (inst_valid && $stable(inst) && $stable(opa) && $stable(opb)));

endmodule

`default_nettype wire

// File: hdl/pe_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module pe_lane
    import pe_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    lane_cmd_if.slave  cmd,
    output logic       lane_valid,
    output lane_data_t lane_result
);

    // valid travels beside the data, one bit per stage
    logic [`PE_LANE_LAT-1:0] vld_sr;

    lane_mode_t s1_mode;
    lane_data_t s1_a;
    lane_data_t s1_b;
    lane_data_t s2_res;
    lane_data_t s3_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`PE_LANE_LAT-2:0], cmd.valid};
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////

    always_ff @(posedge clk) begin
        // stage 1: operand regs
        if (cmd.valid) begin
            s1_mode <= cmd.mode;
            s1_a    <= cmd.a;
            s1_b    <= cmd.b;
        end

        // stage 2: alu, everything wraps at 8 bits
        if (vld_sr[0]) begin
            case (s1_mode)
                mode_add: s2_res <= s1_a + s1_b;
                mode_sub: s2_res <= s1_a - s1_b;
                mode_mul: s2_res <= s1_a * s1_b; // low byte of product
                default:  s2_res <= s1_a;        // pass
            endcase
        end

        // stage 3: output reg
        if (vld_sr[1]) begin
            s3_res <= s2_res;
        end
    end

    assign lane_valid  = vld_sr[`PE_LANE_LAT-1];
    assign lane_result = s3_res;

endmodule

`default_nettype wire

// File: hdl/pe_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module pe_writeback
    import pe_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [`PE_LANES-1:0]      lane_valid,
    input  wire lane_data_t          lane_result [`PE_LANES],
    output logic                     result_valid,
    input  wire                      result_ready,
    output word_t                    result,
    output logic                     credit_return
);

    localparam int PTR_W = $clog2(`PE_WB_DEPTH);

    typedef enum logic [1:0] {
        wb_empty,
        wb_partial,
        wb_full
    } wb_state_e;

    wb_state_e  state;
    credit_t    count;     // entries held
    credit_t    count_nxt;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    word_t      buf_mem [`PE_WB_DEPTH];
    word_t      push_word;
    logic       push;
    logic       pop;

    // lanes run in lockstep, lane 0 speaks for all
    assign push = lane_valid[0];
    assign pop  = result_valid && result_ready;

    always_comb begin
        for (int i = 0; i < `PE_LANES; i++) begin
            push_word[i*`PE_LANE_W +: `PE_LANE_W] = lane_result[i];
        end
    end

    //////////////////////////////
    // circular buffer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr] <= push_word;
        end
    end

    assign count_nxt = count + credit_t'(push) - credit_t'(pop);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            state  <= wb_empty;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count_nxt;
            if (count_nxt == '0) begin
                state <= wb_empty;
            end else if (count_nxt == credit_t'(`PE_WB_DEPTH)) begin
                state <= wb_full;
            end else begin
                state <= wb_partial;
            end
        end
    end

    assign result_valid  = (state != wb_empty);
    assign result        = buf_mem[rd_ptr];
    assign credit_return = pop; // slot freed -> decoder may issue again

    // decoder credits reserve a slot for every push
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (state != wb_full));

    a_lanes_agree: assert property (@(posedge clk) disable iff (!rst_n)
        (&lane_valid) || !(|lane_valid));

endmodule

`default_nettype wire

// File: hdl/pe_array_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module pe_array_top
    import pe_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,

    // instruction in
    input  wire         inst_valid,
    output logic        inst_ready,
    input  wire inst_t  inst,
    input  wire word_t  opa,
    input  wire word_t  opb,

    // result out
    output logic        result_valid,
    input  wire         result_ready,
    output word_t       result
);

    logic                 credit_return;
    logic [`PE_LANES-1:0] lane_valid;
    lane_data_t           lane_result [`PE_LANES];

    lane_cmd_if lane_cmd [`PE_LANES] ();

    pe_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid    (inst_valid),
        .inst_ready    (inst_ready),
        .inst          (inst),
        .opa           (opa),
        .opb           (opb),
        .credit_return (credit_return),
        .lanes         (lane_cmd)
    );

    //////////////////////////////
    // lanes
    //////////////////////////////

    for (genvar i = 0; i < `PE_LANES; i++) begin : g_lane
        pe_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .cmd         (lane_cmd[i]),
            .lane_valid  (lane_valid[i]),
            .lane_result (lane_result[i])
        );
    end

    pe_writeback u_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .lane_valid    (lane_valid),
        .lane_result   (lane_result),
        .result_valid  (result_valid),
        .result_ready  (result_ready),
        .result        (result),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: verif/pe_array_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pe_consts.svh"

module pe_array_tb
    import pe_pkg::*;
();

    localparam int          CLK_PERIOD  = 10;
    localparam int          N_RANDOM    = 300;
    localparam int          N_DIRECTED  = 20;   // sends in the directed part
    localparam int          TOTAL_INSTS = N_DIRECTED + N_RANDOM;
    localparam logic [31:0] LFSR_SEED   = 32'h9df555b5;
    localparam logic [31:0] LFSR_TAPS   = 32'h80200003; // x^32+x^22+x^2+x+1
    localparam word_t       DIR_A       = 32'h05117fc3;
    localparam word_t       DIR_B       = 32'h03228110;

    logic  clk;
    logic  rst_n;
    logic  inst_valid;
    logic  inst_ready;
    inst_t inst;
    word_t opa;
    word_t opb;
    logic  result_valid;
    logic  result_ready;
    word_t result;

    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    int          ready_mode;   // 0 ready high, 1 ready low, 2 random
    word_t       exp_q [$];    // expected words in acceptance order
    int          n_results;

    pe_array_top u_pe_array_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .opa          (opa),
        .opb          (opb),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ LFSR_TAPS; // galois feedback
        return n;
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [31:0] take_bits(input int n, input bit from_ready);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            if (from_ready) begin
                bits[k]    = ready_lfsr[0];
                ready_lfsr = lfsr_next(ready_lfsr);
            end else begin
                bits[k]   = stim_lfsr[0];
                stim_lfsr = lfsr_next(stim_lfsr);
            end
        end
        return bits;
    endfunction

    // expected word from the opcode table with each lane mod 256
    function automatic word_t expected_word(input inst_t i, input word_t a, input word_t b);
        logic [2:0] op;
        int         x;
        int         y;
        int         r;
        word_t      w;
        op = i[31:29];
        w  = '0;
        for (int k = 0; k < `PE_LANES; k++) begin
            x = int'(a[8*k +: 8]);
            y = op[2] ? int'(i[7:0]) : int'(b[8*k +: 8]); // imm broadcast
            case (op[1:0])
                2'b01:   r = x + y;
                2'b10:   r = x - y + 256;  // keep it positive
                2'b11:   r = x * y;
                default: r = x;            // 000 and 100 both load
            endcase
            w[8*k +: 8] = 8'(r % 256);
        end
        return w;
    endfunction

    // middle bits are don't care and get filled
    function automatic inst_t make_inst(input opcode_t op, input lane_data_t imm);
        return {op, 21'h15a5a5, imm};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s, got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    // called 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_inst(input inst_t i, input word_t a, input word_t b,
                             output int stalls);
        logic taken;
        stalls     = 0;
        taken      = 1'b0;
        inst_valid = 1'b1;
        inst       = i;
        opa        = a;
        opb        = b;
        while (!taken) begin
            @(negedge clk);
            taken = inst_ready;
            if (!taken) stalls++;
            @(posedge clk);
            #1;
        end
        inst_valid = 1'b0;
    endtask

    // called 1 ns after an edge and returns at the first negedge with result_valid high
    task automatic wait_result(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!result_valid) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // scoreboard
    //////////////////////////////

    // sample mid-cycle while values hold through the next rising edge
    initial begin
        n_results = 0;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (inst_valid && inst_ready) begin
                    exp_q.push_back(expected_word(inst, opa, opb));
                end
                if (result_valid && result_ready) begin
                    if (exp_q.size() == 0) begin
                        fail_run("result appeared with no instruction outstanding");
                    end else begin
                        check_value(result, exp_q.pop_front(), "result word");
                        n_results++;
                    end
                end
            end
        end
    end

    // output back-pressure from its own copy of the lfsr
    initial begin
        ready_lfsr = LFSR_SEED;
        forever begin
            @(posedge clk);
            #1;
            case (ready_mode)
                0:       result_ready = 1'b1;
                1:       result_ready = 1'b0;
                default: result_ready = (take_bits(2, 1'b1) != 0); // ~3 in 4
            endcase
        end
    end

    initial begin
        repeat (20 * TOTAL_INSTS + 100) @(posedge clk);
        fail_run("run timed out before all results came back");
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        int    lat;
        int    stalls;
        inst_t ri;
        word_t ra;
        word_t rb;

        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        opa          = '0;
        opb          = '0;
        result_ready = 1'b1;
        ready_mode   = 0;
        stim_lfsr    = LFSR_SEED;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle state and then single-op latency
        @(negedge clk);
        check_value(inst_ready, 1'b1, "inst_ready after reset");
        check_value(result_valid, 1'b0, "result_valid after reset");
        @(posedge clk);
        #1;
        send_inst(make_inst(op_add, 8'h00), DIR_A, DIR_B, stalls);
        wait_result(lat);
        check_value(lat, 5, "cycles from accept to result_valid");
        @(posedge clk);
        #1;
        wait_drain();

        // all eight encodings where 100 is the second load
        for (int k = 0; k < 8; k++) begin
            send_inst(make_inst(opcode_t'(k), 8'h07), DIR_A, DIR_B, stalls);
        end

        // wrap inside each lane with no carry across
        wait_drain();
        send_inst(make_inst(op_add, 8'h00), 32'hffffffff, 32'h01010101, stalls);
        wait_result(lat);
        check_value(result, 32'h00000000, "add wrap in every lane");
        @(posedge clk);
        #1;
        send_inst(make_inst(op_sub, 8'h00), 32'h00010203, 32'h01010101, stalls);
        send_inst(make_inst(op_mul, 8'h00), 32'h10ff8003, 32'h10ff0255, stalls);

        // immediates ignore opb
        send_inst(make_inst(op_addi, 8'h01), 32'h00ff7f80, 32'hdeadbeef, stalls);
        send_inst(make_inst(op_subi, 8'h02), 32'h00ff7f80, 32'hdeadbeef, stalls);
        send_inst(make_inst(op_muli, 8'h03), 32'h00ff7f80, 32'hdeadbeef, stalls);
        wait_drain();

        // back-pressure with four credits and then a stall
        ready_mode = 1;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < `PE_WB_DEPTH; k++) begin
            send_inst(make_inst(opcode_t'(k + 1), 8'h11), DIR_A + k, DIR_B, stalls);
            check_value(stalls, 0, "stall before buffer full");
        end
        inst_valid = 1'b1;
        inst       = make_inst(op_muli, 8'h05);
        opa        = DIR_B;
        opb        = DIR_A;
        repeat (6) begin
            @(negedge clk);
            check_value(inst_ready, 1'b0, "inst_ready with four results held");
        end
        @(posedge clk);
        #1;
        ready_mode = 0;
        send_inst(make_inst(op_muli, 8'h05), DIR_B, DIR_A, stalls);
        wait_drain();

        // random stream
        ready_mode = 2;
        for (int n = 0; n < N_RANDOM; n++) begin
            if (take_bits(2, 1'b0) == 0) begin
                @(posedge clk); // idle gap
                #1;
            end
            ri = take_bits(32, 1'b0);
            ra = take_bits(32, 1'b0);
            rb = take_bits(32, 1'b0);
            send_inst(ri, ra, rb, stalls);
        end
        ready_mode = 0;
        wait_drain();
        repeat (10) @(posedge clk); // catch any stray extra result

        if (n_results == TOTAL_INSTS && exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run($sformatf("saw %0d results, expected %0d", n_results, TOTAL_INSTS));
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/pe_pkg.sv
hdl/pe_lane_if.sv
hdl/pe_decoder.sv
hdl/pe_lane.sv
hdl/pe_writeback.sv
hdl/pe_array_top.sv
verif/pe_array_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module pe_array_tb \
    -f project.f -o pe_array_sim

if ./obj_dir/pe_array_sim 2>&1 | tee /dev/stderr | grep -x "all tests passed" > /dev/null; then
    echo "simulation ok"
else
    echo "simulation failed"
    exit 1
fi
